// ==== rtl/glay_params.svh ====
// GLay read/write stage parameters: packet geometry, lane count and address widths
`ifndef GLAY_PARAMS_SVH
`define GLAY_PARAMS_SVH

// ---------------------------------------------------------------------------
// Packet geometry
// ---------------------------------------------------------------------------
// Fields carried by every engine packet
`define GLAY_NUM_FIELDS 4
// Bits per field
`define GLAY_FIELD_WIDTH 32

// ---------------------------------------------------------------------------
// Lane and request address geometry
// ---------------------------------------------------------------------------
// Identical kernel lanes behind the dispatcher
`define GLAY_NUM_LANES 4
// Request offset, wraps at this width
`define GLAY_OFFSET_WIDTH 32
// Granularity shift amount
`define GLAY_SHIFT_WIDTH 5
// Channel and buffer identifiers
`define GLAY_ID_WIDTH 8

`endif

// ==== rtl/glay_pkg.sv ====
// GLay shared types for fields, packets, read/write configuration and request addresses
`include "glay_params.svh"

package glay_pkg;

  // ---------------------------------------------------------------------------
  // Plain vector types
  // ---------------------------------------------------------------------------
  // One data field of a packet
  typedef logic [`GLAY_FIELD_WIDTH-1:0] field_t;

  // One bit per field, used for the constant mask and each ops_mask row
  typedef logic [`GLAY_NUM_FIELDS-1:0] field_mask_t;

  // Request offset and its base
  typedef logic [`GLAY_OFFSET_WIDTH-1:0] offset_t;

  // Granularity shift amount
  typedef logic [`GLAY_SHIFT_WIDTH-1:0] shift_amount_t;

  // Channel or buffer identifier
  typedef logic [`GLAY_ID_WIDTH-1:0] id_t;

  // Burst length of a request, always 1 here
  typedef logic [7:0] burst_length_t;

  // Lane index
  typedef logic [$clog2(`GLAY_NUM_LANES)-1:0] lane_sel_t;

  // ---------------------------------------------------------------------------
  // Packet and configuration
  // ---------------------------------------------------------------------------
  // Group of fields moving as one packet
  typedef struct packed {
    field_t [`GLAY_NUM_FIELDS-1:0] field;
  } engine_packet_t;

  // Read/write kernel configuration, latched on cfg_load
  typedef struct packed {
    field_mask_t                        const_mask;
    field_t                             const_value;
    // Row i selects the input field for output field i
    field_mask_t [`GLAY_NUM_FIELDS-1:0] ops_mask;
    offset_t                            index_start;
    shift_amount_t                      granularity;
    // 1 shifts left, 0 shifts right
    logic                               direction;
    id_t                                id_channel;
    id_t                                id_buffer;
  } rw_config_t;

  // ---------------------------------------------------------------------------
  // Memory request
  // ---------------------------------------------------------------------------
  // Shift applied to the offset, forwarded as metadata
  typedef struct packed {
    shift_amount_t amount;
    logic          direction;
  } shift_t;

  // Request address handed to the memory side
  typedef struct packed {
    offset_t       offset;
    shift_t        shift;
    id_t           id_channel;
    id_t           id_buffer;
    burst_length_t burst_length;
  } request_address_t;

endpackage : glay_pkg

// ==== rtl/engine_read_write_kernel.sv ====
// Read/write kernel lane: routes packet fields and forms the tagged memory request address
`timescale 1ns/1ps
`include "glay_params.svh"

module engine_read_write_kernel (
  input  logic                        ap_clk,
  input  logic                        reset,
  input  glay_pkg::rw_config_t        config_params,
  input  logic                        valid,
  input  glay_pkg::engine_packet_t    data,
  output logic                        address_valid,
  output glay_pkg::request_address_t  address,
  output glay_pkg::engine_packet_t    result
);

  // Routed fields, before and after the constant override
  glay_pkg::engine_packet_t   routed_value;
  glay_pkg::engine_packet_t   ops_value;

  // Stage 1 registers
  logic                       valid_s1;
  glay_pkg::engine_packet_t   ops_value_s1;
  glay_pkg::engine_packet_t   org_value_s1;

  // Stage 2 registers
  logic                       valid_s2;
  glay_pkg::request_address_t address_s2;
  glay_pkg::engine_packet_t   result_s2;

  // Offset base plus field 1, wrapped at the offset width
  glay_pkg::offset_t          offset_sum;
  glay_pkg::offset_t          offset_shifted;

  // ---------------------------------------------------------------------------
  // Stage 1: field routing
  // ---------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < `GLAY_NUM_FIELDS; i++) begin
      // Empty row gives zero
      routed_value.field[i] = '0;
      // Ascending scan, so the highest set bit wins
      for (int j = 0; j < `GLAY_NUM_FIELDS; j++) begin
        if (config_params.ops_mask[i][j]) begin
          routed_value.field[i] = data.field[j];
        end
      end
      // Constant override only affects the operand copy
      if (config_params.const_mask[i]) begin
        ops_value.field[i] = config_params.const_value;
      end else begin
        ops_value.field[i] = routed_value.field[i];
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    ops_value_s1 <= ops_value;
    org_value_s1 <= routed_value;
  end

  // ---------------------------------------------------------------------------
  // Stage 2: address computation
  // ---------------------------------------------------------------------------
  // Field 1 carries the offset
  assign offset_sum = config_params.index_start + glay_pkg::offset_t'(ops_value_s1.field[1]);

  always_comb begin
    if (config_params.direction) begin
      offset_shifted = offset_sum << config_params.granularity;
    end else begin
      offset_shifted = offset_sum >> config_params.granularity;
    end
  end

  always_ff @(posedge ap_clk) begin
    address_s2.offset          <= offset_shifted;
    address_s2.shift.amount    <= config_params.granularity;
    address_s2.shift.direction <= config_params.direction;
    address_s2.id_channel      <= config_params.id_channel;
    address_s2.id_buffer       <= config_params.id_buffer;
    // Single beat requests only
    address_s2.burst_length    <= glay_pkg::burst_length_t'(1);
    // Original routed fields pass through as the result
    result_s2                  <= org_value_s1;
  end

  // ---------------------------------------------------------------------------
  // Stage 3: output register
  // ---------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    address <= address_s2;
    result  <= result_s2;
  end

  // Valid bit travels alongside the three stages
  always_ff @(posedge ap_clk) begin
    if (reset) begin
      valid_s1      <= 1'b0;
      valid_s2      <= 1'b0;
      address_valid <= 1'b0;
    end else begin
      valid_s1      <= valid;
      valid_s2      <= valid_s1;
      address_valid <= valid_s2;
    end
  end

  // Stages 1 and 2 read the config on different cycles for the same packet
  config_stable_in_flight : assert property (
    @(posedge ap_clk) disable iff (reset)
    (valid || valid_s1 || valid_s2) |-> $stable(config_params)
  ) else $error("config_params changed while a packet was in the kernel");

endmodule : engine_read_write_kernel

// ==== rtl/engine_lane_dispatch.sv ====
// Lane dispatcher: latches the kernel configuration and deals packets to lanes in rotation
`timescale 1ns/1ps
`include "glay_params.svh"

module engine_lane_dispatch (
  input  logic                          ap_clk,
  input  logic                          reset,
  input  logic                          cfg_load,
  input  glay_pkg::rw_config_t          cfg_in,
  input  logic                          in_valid,
  input  glay_pkg::engine_packet_t      in_data,
  output logic [`GLAY_NUM_LANES-1:0]    lane_valid,
  output glay_pkg::engine_packet_t      lane_data,
  output glay_pkg::rw_config_t          lane_config
);

  // Cycles from capture here to out_valid at the top
  localparam int PIPE_LATENCY = 5;
  localparam int COUNT_WIDTH  = $clog2(PIPE_LATENCY + 1);

  // Next lane to receive a packet
  glay_pkg::lane_sel_t       lane_ptr;

  // In-flight tracking
  logic [PIPE_LATENCY-1:0]   flight_pipe;
  logic [COUNT_WIDTH-1:0]    flight_count;
  logic                      retire;

  // ---------------------------------------------------------------------------
  // Configuration register
  // ---------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (reset) begin
      lane_config <= '0;
    end else if (cfg_load) begin
      lane_config <= cfg_in;
    end
  end

  // ---------------------------------------------------------------------------
  // Rotation and lane steering
  // ---------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (reset) begin
      lane_ptr   <= '0;
      lane_valid <= '0;
    end else begin
      // One-hot strobe for the lane under the pointer
      lane_valid <= '0;
      if (in_valid) begin
        lane_valid[lane_ptr] <= 1'b1;
        if (lane_ptr == glay_pkg::lane_sel_t'(`GLAY_NUM_LANES - 1)) begin
          lane_ptr <= '0;
        end else begin
          lane_ptr <= lane_ptr + 1'b1;
        end
      end
    end
  end

  // Data is shared by all lanes, only the strobe picks one
  always_ff @(posedge ap_clk) begin
    lane_data <= in_data;
  end

  // ---------------------------------------------------------------------------
  // In-flight counter
  // ---------------------------------------------------------------------------
  // Packet retires on the edge that registers it at the top output
  assign retire = flight_pipe[PIPE_LATENCY-1];

  always_ff @(posedge ap_clk) begin
    if (reset) begin
      flight_pipe  <= '0;
      flight_count <= '0;
    end else begin
      flight_pipe  <= {flight_pipe[PIPE_LATENCY-2:0], in_valid};
      flight_count <= flight_count + COUNT_WIDTH'(in_valid) - COUNT_WIDTH'(retire);
    end
  end

  // Reload only while the whole pipeline is empty
  cfg_load_when_idle : assert property (
    @(posedge ap_clk) disable iff (reset)
    cfg_load |-> (!in_valid && (flight_count == '0))
  ) else $error("cfg_load asserted with a packet in flight");

endmodule : engine_lane_dispatch

// ==== rtl/engine_request_merge.sv ====
// Request merge: picks the one lane with a valid output and registers it to the top outputs
`timescale 1ns/1ps
`include "glay_params.svh"

module engine_request_merge (
  input  logic                        ap_clk,
  input  logic                        reset,
  input  logic [`GLAY_NUM_LANES-1:0]  kern_valid,
  input  glay_pkg::request_address_t  kern_address [`GLAY_NUM_LANES],
  input  glay_pkg::engine_packet_t    kern_result  [`GLAY_NUM_LANES],
  output logic                        out_valid,
  output glay_pkg::request_address_t  out_address,
  output glay_pkg::engine_packet_t    out_result,
  output glay_pkg::lane_sel_t         out_lane
);

  // Index of the valid lane, zero when none
  glay_pkg::lane_sel_t        sel_lane;
  logic                       any_valid;

  // Selected lane payload
  glay_pkg::request_address_t sel_address;
  glay_pkg::engine_packet_t   sel_result;

  // ---------------------------------------------------------------------------
  // Lane encode and mux
  // ---------------------------------------------------------------------------
  always_comb begin
    sel_lane = '0;
    for (int k = 0; k < `GLAY_NUM_LANES; k++) begin
      if (kern_valid[k]) begin
        sel_lane = glay_pkg::lane_sel_t'(k);
      end
    end
  end

  assign any_valid   = |kern_valid;
  assign sel_address = kern_address[sel_lane];
  assign sel_result  = kern_result[sel_lane];

  // ---------------------------------------------------------------------------
  // Output register
  // ---------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= any_valid;
    end
  end

  // Payload only meaningful with out_valid
  always_ff @(posedge ap_clk) begin
    out_address <= sel_address;
    out_result  <= sel_result;
    out_lane    <= sel_lane;
  end

  // Rotation gives at most one lane finishing per cycle
  kern_valid_onehot : assert property (
    @(posedge ap_clk) disable iff (reset)
    $onehot0(kern_valid)
  ) else $error("more than one kernel lane valid in the same cycle");

endmodule : engine_request_merge

// ==== rtl/engine_read_write_top.sv ====
// Read/write address stage top: dispatcher, parallel kernel lanes and output merge
`timescale 1ns/1ps
`include "glay_params.svh"

module engine_read_write_top (
  input  logic                        ap_clk,
  input  logic                        reset,
  input  logic                        cfg_load,
  input  glay_pkg::rw_config_t        cfg_in,
  input  logic                        in_valid,
  input  glay_pkg::engine_packet_t    in_data,
  output logic                        out_valid,
  output glay_pkg::request_address_t  out_address,
  output glay_pkg::engine_packet_t    out_result,
  output glay_pkg::lane_sel_t         out_lane
);

  // ---------------------------------------------------------------------------
  // Dispatcher to lanes
  // ---------------------------------------------------------------------------
  logic [`GLAY_NUM_LANES-1:0] lane_valid;
  // Shared by every lane
  glay_pkg::engine_packet_t   lane_data;
  glay_pkg::rw_config_t       lane_config;

  // ---------------------------------------------------------------------------
  // Lanes to merge
  // ---------------------------------------------------------------------------
  logic [`GLAY_NUM_LANES-1:0] kern_valid;
  glay_pkg::request_address_t kern_address [`GLAY_NUM_LANES];
  glay_pkg::engine_packet_t   kern_result  [`GLAY_NUM_LANES];

  // Config latch and round-robin steering
  engine_lane_dispatch engine_lane_dispatch_i (
    .ap_clk      (ap_clk),
    .reset       (reset),
    .cfg_load    (cfg_load),
    .cfg_in      (cfg_in),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .lane_valid  (lane_valid),
    .lane_data   (lane_data),
    .lane_config (lane_config)
  );

  // One kernel per lane
  generate
    for (genvar k = 0; k < `GLAY_NUM_LANES; k++) begin : g_lane
      engine_read_write_kernel engine_read_write_kernel_i (
        .ap_clk        (ap_clk),
        .reset         (reset),
        .config_params (lane_config),
        .valid         (lane_valid[k]),
        .data          (lane_data),
        .address_valid (kern_valid[k]),
        .address       (kern_address[k]),
        .result        (kern_result[k])
      );
    end
  endgenerate

  // Drain lanes into the single output port
  engine_request_merge engine_request_merge_i (
    .ap_clk       (ap_clk),
    .reset        (reset),
    .kern_valid   (kern_valid),
    .kern_address (kern_address),
    .kern_result  (kern_result),
    .out_valid    (out_valid),
    .out_address  (out_address),
    .out_result   (out_result),
    .out_lane     (out_lane)
  );

endmodule : engine_read_write_top

// ==== tests/engine_read_write_model.svh ====
// Reference model of the read/write stage and Galois LFSR stimulus source
`ifndef ENGINE_READ_WRITE_MODEL_SVH
`define ENGINE_READ_WRITE_MODEL_SVH

// Stimulus LFSR state
logic [31:0] lfsr_state = 32'h73d6;

// One Galois step, returns the bit shifted out
function automatic logic lfsr_next_bit();
  logic out_bit;
  out_bit    = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (out_bit) begin
    lfsr_state = lfsr_state ^ 32'hd000_0001;
  end
  return out_bit;
endfunction

// Gathers width bits, one LFSR step per bit
function automatic logic [31:0] random_bits(input int width);
  logic [31:0] value;
  value = '0;
  for (int b = 0; b < width; b++) begin
    value = {value[30:0], lfsr_next_bit()};
  end
  return value;
endfunction

// Output field i takes the input field at the highest set bit of row i
function automatic glay_pkg::engine_packet_t route_fields(
  input glay_pkg::rw_config_t cfg, input glay_pkg::engine_packet_t pkt);
  glay_pkg::engine_packet_t routed;
  logic                     found;
  routed = '0;
  for (int i = 0; i < `GLAY_NUM_FIELDS; i++) begin
    found = 1'b0;
    // Search from the top, first hit wins
    for (int j = `GLAY_NUM_FIELDS - 1; j >= 0; j--) begin
      if (!found && cfg.ops_mask[i][j]) begin
        routed.field[i] = pkt.field[j];
        found           = 1'b1;
      end
    end
  end
  return routed;
endfunction

// Request address with constant override on field 1
function automatic glay_pkg::request_address_t predict_address(
  input glay_pkg::rw_config_t cfg, input glay_pkg::engine_packet_t pkt);
  glay_pkg::engine_packet_t   routed;
  glay_pkg::offset_t          offset;
  glay_pkg::request_address_t addr;
  routed = route_fields(cfg, pkt);
  offset = cfg.index_start + (cfg.const_mask[1] ? cfg.const_value : routed.field[1]);
  // One position per step, bits fall off at the offset width
  for (int s = 0; s < int'(cfg.granularity); s++) begin
    offset = cfg.direction ? (offset << 1) : (offset >> 1);
  end
  addr.offset          = offset;
  addr.shift.amount    = cfg.granularity;
  addr.shift.direction = cfg.direction;
  addr.id_channel      = cfg.id_channel;
  addr.id_buffer       = cfg.id_buffer;
  addr.burst_length    = 8'd1;
  return addr;
endfunction

`endif

// ==== tests/engine_read_write_tb.sv ====
// Testbench for the read/write address stage with predicted beats and concurrent checks
`timescale 1ns/1ps
`include "glay_params.svh"

module engine_read_write_tb;

  // Capture to out_valid, in cycles
  localparam int LATENCY     = 5;
  localparam int DRAIN_LIMIT = 64;

  // Prediction for one packet
  typedef struct packed {
    glay_pkg::request_address_t address;
    glay_pkg::engine_packet_t   result;
    glay_pkg::lane_sel_t        lane;
    logic [31:0]                capture_cycle;
  } expect_t;

  logic                       ap_clk = 1'b0;
  logic                       reset;
  logic                       cfg_load;
  glay_pkg::rw_config_t       cfg_in;
  logic                       in_valid;
  glay_pkg::engine_packet_t   in_data;
  logic                       out_valid;
  glay_pkg::request_address_t out_address;
  glay_pkg::engine_packet_t   out_result;
  glay_pkg::lane_sel_t        out_lane;

  // Model state
  glay_pkg::rw_config_t       cfg_model = '0;
  expect_t                    exp_q[$];
  expect_t                    head = '0;
  logic                       head_valid = 1'b0;
  logic                       last_out_valid = 1'b0;
  logic [31:0]                cycle_count = '0;
  int                         send_count = 0;
  string                      test_name = "init";

  `include "engine_read_write_model.svh"

  engine_read_write_top engine_read_write_top_i (
    .ap_clk      (ap_clk),
    .reset       (reset),
    .cfg_load    (cfg_load),
    .cfg_in      (cfg_in),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .out_valid   (out_valid),
    .out_address (out_address),
    .out_result  (out_result),
    .out_lane    (out_lane)
  );

  always #2 ap_clk = ~ap_clk;

  always @(posedge ap_clk) begin
    cycle_count    <= cycle_count + 32'd1;
    last_out_valid <= out_valid;
  end

  // Retire the checked beat and expose the next prediction, away from the rising edge
  always @(negedge ap_clk) begin
    if (last_out_valid && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
    end
    head_valid = (exp_q.size() > 0);
    if (head_valid) begin
      head = exp_q[0];
    end
  end

  // --------------------------------------------------------------------------
  // Failure reporting
  // --------------------------------------------------------------------------
  task automatic stop_with_failure();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on the first failure");
  endtask

  task automatic report_mismatch(input string what, input logic [127:0] expected,
                                 input logic [127:0] actual);
    $display("ERROR %s %s: expected %0h actual %0h", test_name, what, expected, actual);
    stop_with_failure();
  endtask

  // --------------------------------------------------------------------------
  // Output checks
  // --------------------------------------------------------------------------
  beat_expected : assert property (@(posedge ap_clk) disable iff (reset)
    out_valid |-> head_valid)
  else begin
    $display("Output beat with no packet outstanding in %s", test_name);
    stop_with_failure();
  end

  // Beat overdue
  beat_on_time : assert property (@(posedge ap_clk) disable iff (reset)
    (head_valid && cycle_count >= head.capture_cycle + 32'(LATENCY)) |-> out_valid)
  else begin
    $display("Output beat missing %0d cycles after capture in %s", LATENCY, test_name);
    stop_with_failure();
  end

  beat_latency : assert property (@(posedge ap_clk) disable iff (reset)
    out_valid |-> (cycle_count == head.capture_cycle + 32'(LATENCY)))
  else report_mismatch("latency", 128'($sampled(head.capture_cycle) + 32'(LATENCY)),
                       128'($sampled(cycle_count)));

  beat_address : assert property (@(posedge ap_clk) disable iff (reset)
    out_valid |-> (out_address == head.address))
  else report_mismatch("address", 128'($sampled(head.address)), 128'($sampled(out_address)));

  beat_result : assert property (@(posedge ap_clk) disable iff (reset)
    out_valid |-> (out_result == head.result))
  else report_mismatch("result", 128'($sampled(head.result)), 128'($sampled(out_result)));

  beat_lane : assert property (@(posedge ap_clk) disable iff (reset)
    out_valid |-> (out_lane == head.lane))
  else report_mismatch("lane", 128'($sampled(head.lane)), 128'($sampled(out_lane)));

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------
  function automatic glay_pkg::engine_packet_t random_packet();
    glay_pkg::engine_packet_t pkt;
    for (int i = 0; i < `GLAY_NUM_FIELDS; i++) begin
      pkt.field[i] = random_bits(`GLAY_FIELD_WIDTH);
    end
    return pkt;
  endfunction

  function automatic glay_pkg::rw_config_t random_config();
    glay_pkg::rw_config_t cfg;
    cfg.const_mask  = glay_pkg::field_mask_t'(random_bits(`GLAY_NUM_FIELDS));
    cfg.const_value = random_bits(`GLAY_FIELD_WIDTH);
    for (int i = 0; i < `GLAY_NUM_FIELDS; i++) begin
      cfg.ops_mask[i] = glay_pkg::field_mask_t'(random_bits(`GLAY_NUM_FIELDS));
    end
    cfg.index_start = random_bits(`GLAY_OFFSET_WIDTH);
    cfg.granularity = glay_pkg::shift_amount_t'(random_bits(`GLAY_SHIFT_WIDTH));
    cfg.direction   = lfsr_next_bit();
    cfg.id_channel  = glay_pkg::id_t'(random_bits(`GLAY_ID_WIDTH));
    cfg.id_buffer   = glay_pkg::id_t'(random_bits(`GLAY_ID_WIDTH));
    return cfg;
  endfunction

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge ap_clk);
      in_valid <= 1'b0;
    end
  endtask

  // One-cycle strobe, pipeline must be empty
  task automatic load_config(input glay_pkg::rw_config_t cfg);
    @(posedge ap_clk);
    cfg_load <= 1'b1;
    cfg_in   <= cfg;
    @(posedge ap_clk);
    cfg_load <= 1'b0;
    cfg_model = cfg;
  endtask

  task automatic send_packet(input glay_pkg::engine_packet_t pkt);
    expect_t item;
    @(posedge ap_clk);
    in_valid <= 1'b1;
    in_data  <= pkt;
    item.address       = predict_address(cfg_model, pkt);
    item.result        = route_fields(cfg_model, pkt);
    item.lane          = glay_pkg::lane_sel_t'(send_count % `GLAY_NUM_LANES);
    // Dispatcher captures on the next edge
    item.capture_cycle = cycle_count + 32'd1;
    exp_q.push_back(item);
    send_count++;
  endtask

  // Back-to-back packets
  task automatic send_burst(input int count);
    for (int n = 0; n < count; n++) begin
      send_packet(random_packet());
    end
    @(posedge ap_clk);
    in_valid <= 1'b0;
  endtask

  // Wait until every prediction is retired
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge ap_clk);
      in_valid <= 1'b0;
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Outputs still missing after %0d cycles in %s", DRAIN_LIMIT, test_name);
      stop_with_failure();
    end else begin
      idle(2);
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    glay_pkg::rw_config_t cfg;
    reset    = 1'b1;
    cfg_load = 1'b0;
    cfg_in   = '0;
    in_valid = 1'b0;
    in_data  = '0;
    repeat (2) @(posedge ap_clk);
    reset <= 1'b0;

    // Quiet after reset, then one packet through the all-zero config
    test_name = "reset_latency";
    idle(8);
    send_burst(1);
    drain();

    // Single bit, highest of several, empty row
    test_name = "field_routing";
    cfg = random_config();
    cfg.ops_mask[0] = 4'b0001;
    cfg.ops_mask[1] = 4'b0100;
    cfg.ops_mask[2] = 4'b1010;
    cfg.ops_mask[3] = 4'b0000;
    cfg.const_mask  = 4'b1101;
    load_config(cfg);
    send_burst(6);
    drain();

    test_name = "const_override";
    cfg = random_config();
    cfg.const_mask  = 4'b0010;
    cfg.granularity = '0;
    load_config(cfg);
    send_burst(4);
    drain();

    // Both directions at 0 and 31, then a wrapping base
    test_name = "shifts";
    for (int k = 0; k < 6; k++) begin
      cfg = random_config();
      cfg.direction   = k[0];
      cfg.granularity = (k < 2) ? 5'd0 : ((k < 4) ? 5'd31 : 5'd13);
      if (k >= 4) begin
        cfg.index_start = '1;
      end
      load_config(cfg);
      send_burst(4);
      drain();
    end

    test_name = "metadata_reload";
    for (int k = 0; k < 3; k++) begin
      load_config(random_config());
      send_burst(3);
      drain();
      idle(4);
    end

    // Several laps of the rotation
    test_name = "full_rate";
    load_config(random_config());
    send_burst(4 * `GLAY_NUM_LANES + 3);
    drain();

    if (exp_q.size() == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Predictions left over at the end of the run");
      stop_with_failure();
    end
  end

endmodule : engine_read_write_tb

// ==== list.f ====
+incdir+rtl
+incdir+tests
rtl/glay_pkg.sv
rtl/engine_read_write_kernel.sv
rtl/engine_lane_dispatch.sv
rtl/engine_request_merge.sv
rtl/engine_read_write_top.sv
tests/engine_read_write_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the read/write stage testbench with Verilator and run it
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module engine_read_write_tb \
    -f list.f -o engine_read_write_sim &&
  ./obj_dir/engine_read_write_sim ||
  exit 1
